/* include/adc_macros.svh */
// adc78h90 scan subsystem sizes: clock division, frame length, channels and fifo depth
`ifndef ADC_MACROS_SVH
`define ADC_MACROS_SVH

// clock cycles per sclk period, one per sequencer bit state
`define ADC_SCLK_DIV 4

// serial frame length in sclk periods, 4 leading zeros then 12 result bits
`define ADC_FRAME_BITS 16

// scanned inputs AIN1 to AIN5, addresses 0 to 4
`define ADC_NUM_CHANNELS 5

// sample fifo entries, equal to the sequencer's credits after reset
`define ADC_FIFO_DEPTH 4

// forward power sensor sits on AIN5
`define ADC_FWD_CHANNEL 4

`endif

/* design/adc_pkg.sv */
// shared types for the adc78h90 scan path: samples, channel tags, credits and sequencer states
package adc_pkg;

	typedef logic [11:0] adc_sample_t;   // one 12-bit conversion result
	typedef logic [2:0]  adc_chan_t;     // input address as sent in control word bits 13:11
	typedef logic [2:0]  adc_credit_t;   // sequencer credits, holds 0 to fifo depth

	// one bit of the serial frame takes select, sclk_high, sclk_low, next_bit
	typedef enum logic [2:0] {
		seq_idle,        // ncs high between frames, waits here without credit
		seq_select,      // ncs low, mosi updated
		seq_sclk_high,   // sclk rises, miso sampled
		seq_sclk_low,    // sclk falls, converter shifts next bit
		seq_next_bit     // count down or close the frame
	} adc_seq_state_t;

endpackage

/* design/adc_spi_sequencer.sv */
// adc78h90 serial sequencer: scans AIN1..AIN5 and pushes tagged results against fifo credits
`timescale 1ns/100ps
`include "adc_macros.svh"

module adc_spi_sequencer import adc_pkg::*; (
	input  logic        clock,
	input  logic        rst_n,
	input  logic        credit_return,   // one pulse per entry freed in the fifo
	output logic        ncs,
	output logic        sclk,
	output logic        mosi,
	input  logic        miso,
	output logic        push,
	output adc_chan_t   push_chan,
	output adc_sample_t push_sample
);

	localparam int bit_w = $clog2(`ADC_FRAME_BITS);
	localparam logic [bit_w-1:0] last_bit = bit_w'(`ADC_FRAME_BITS - 1);
	localparam adc_chan_t last_chan = adc_chan_t'(`ADC_NUM_CHANNELS - 1);

	adc_seq_state_t state;
	logic [bit_w-1:0] bit_cnt;                 // counts frame bits down to 0
	logic [`ADC_FRAME_BITS-1:0] ctrl_word;     // msb goes out first
	adc_chan_t   addr;                         // address sent in this frame
	adc_chan_t   tag;                          // address sent in the previous frame
	adc_sample_t rx_shift;                     // keeps the last 12 bits seen on miso
	adc_credit_t credit_cnt;
	logic        first_frame;                  // result of the first frame has no owner
	logic        frame_end;
	logic        push_now;

	// control word: two don't-care bits, then ADD2..ADD0, rest zero
	assign ctrl_word = {2'b00, addr, 11'b0};

	assign frame_end = (state == seq_next_bit) && (bit_cnt == '0);
	assign push_now  = frame_end && !first_frame;   // credit was checked at frame start

	// frame fsm, outputs registered like the sclk divider they come from
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state   <= seq_idle;
			bit_cnt <= last_bit;
			ncs     <= 1'b1;
			sclk    <= 1'b0;
			mosi    <= 1'b0;
		end else begin
			case (state)
				seq_idle: begin
					ncs     <= 1'b1;
					bit_cnt <= last_bit;
					if (credit_cnt != '0)   // no room downstream, hold the bus quiet
						state <= seq_select;
				end
				seq_select: begin
					ncs   <= 1'b0;
					mosi  <= ctrl_word[bit_cnt];
					state <= seq_sclk_high;
				end
				seq_sclk_high: begin
					sclk  <= 1'b1;
					state <= seq_sclk_low;
				end
				seq_sclk_low: begin
					sclk  <= 1'b0;
					state <= seq_next_bit;
				end
				seq_next_bit: begin
					if (bit_cnt == '0) begin
						state <= seq_idle;
					end else begin
						bit_cnt <= bit_cnt - 1'b1;
						state   <= seq_select;
					end
				end
				default: state <= seq_idle;
			endcase
		end
	end

	// miso taken on the rising sclk edge, converter changed it on the previous fall
	always_ff @(posedge clock) begin
		if (state == seq_sclk_high)
			rx_shift <= {rx_shift[10:0], miso};
	end

	// channel scan and result tagging
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			addr        <= '0;
			tag         <= '0;
			first_frame <= 1'b1;
		end else if (frame_end) begin
			tag         <= addr;                              // next result belongs to addr
			addr        <= (addr == last_chan) ? '0 : addr + 1'b1;
			first_frame <= 1'b0;
		end
	end

	// push strobe, high in the idle cycle right after the last bit
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			push <= 1'b0;
		else
			push <= push_now;
	end

	// payload for the fifo
	always_ff @(posedge clock) begin
		if (push_now) begin
			push_chan   <= tag;        // the frame just closed returned tag's conversion
			push_sample <= rx_shift;
		end
	end

	// one credit spent per push, one back per returned entry
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			credit_cnt <= adc_credit_t'(`ADC_FIFO_DEPTH);
		else
			credit_cnt <= credit_cnt + adc_credit_t'(credit_return) - adc_credit_t'(push_now);
	end

endmodule

/* design/adc_sample_fifo.sv */
// tagged sample fifo between sequencer and monitor, hands one credit back per released entry
`timescale 1ns/100ps
`include "adc_macros.svh"

module adc_sample_fifo import adc_pkg::*; (
	input  logic        clock,
	input  logic        rst_n,
	input  logic        push,
	input  adc_chan_t   push_chan,
	input  adc_sample_t push_sample,
	input  logic        pop,
	output logic        valid,
	output adc_chan_t   pop_chan,
	output adc_sample_t pop_sample,
	output logic        credit_return
);

	localparam int ptr_w = $clog2(`ADC_FIFO_DEPTH);
	localparam int cnt_w = $clog2(`ADC_FIFO_DEPTH + 1);

	adc_chan_t   chan_mem [`ADC_FIFO_DEPTH];
	adc_sample_t data_mem [`ADC_FIFO_DEPTH];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;          // entries held, 0 to depth
	logic             do_pop;

	assign valid      = (count != '0);
	assign do_pop     = pop && valid;   // empty pops are ignored
	assign pop_chan   = chan_mem[rd_ptr];
	assign pop_sample = data_mem[rd_ptr];

	// storage, no full check since the sequencer only pushes with credit
	always_ff @(posedge clock) begin
		if (push) begin
			chan_mem[wr_ptr] <= push_chan;
			data_mem[wr_ptr] <= push_sample;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two, wraps by itself
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;     // both or neither
			endcase
		end
	end

	// freed slot goes back to the sequencer one cycle after the pop
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			credit_return <= 1'b0;
		else
			credit_return <= do_pop;
	end

endmodule

/* design/adc_power_monitor.sv */
// latest-reading store per channel with read port and AIN5 forward power alarm
`timescale 1ns/100ps
`include "adc_macros.svh"

module adc_power_monitor import adc_pkg::*; (
	input  logic        clock,
	input  logic        rst_n,
	input  logic        hold,         // freezes consumption, fifo fills and stalls the scan
	input  logic        valid,
	output logic        pop,
	input  adc_chan_t   pop_chan,
	input  adc_sample_t pop_sample,
	input  adc_sample_t fwd_limit,
	input  adc_chan_t   read_chan,
	output adc_sample_t read_value,
	output logic        fwd_alarm
);

	localparam adc_chan_t num_chan = adc_chan_t'(`ADC_NUM_CHANNELS);

	adc_sample_t chan_val [`ADC_NUM_CHANNELS];   // latest result per input

	// take the head entry whenever there is one and we are not held
	assign pop = valid && !hold;

	// register file, channels read zero until their first real result
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `ADC_NUM_CHANNELS; i++)
				chan_val[i] <= '0;
		end else if (pop && (pop_chan < num_chan)) begin
			chan_val[pop_chan] <= pop_sample;
		end
	end

	// read port and alarm, one cycle behind the store
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			read_value <= '0;
			fwd_alarm  <= 1'b0;
		end else begin
			read_value <= (read_chan < num_chan) ? chan_val[read_chan] : '0;   // unused inputs read 0
			fwd_alarm  <= (chan_val[`ADC_FWD_CHANNEL] > fwd_limit);        // strictly above limit
		end
	end

endmodule

/* design/adc_subsystem.sv */
// adc78h90 subsystem top: serial sequencer feeding the sample fifo feeding the power monitor
`timescale 1ns/100ps

module adc_subsystem import adc_pkg::*; (
	input  logic        clock,
	input  logic        rst_n,
	output logic        ncs,
	output logic        sclk,
	output logic        mosi,
	input  logic        miso,
	input  logic        hold,
	input  adc_sample_t fwd_limit,
	input  adc_chan_t   read_chan,
	output adc_sample_t read_value,
	output logic        fwd_alarm
);

	// sequencer to fifo
	logic        push;
	adc_chan_t   push_chan;
	adc_sample_t push_sample;
	logic        credit_return;

	// fifo to monitor
	logic        pop;
	logic        valid;
	adc_chan_t   pop_chan;
	adc_sample_t pop_sample;

	adc_spi_sequencer i_sequencer (
		.clock         (clock),
		.rst_n         (rst_n),
		.credit_return (credit_return),
		.ncs           (ncs),
		.sclk          (sclk),
		.mosi          (mosi),
		.miso          (miso),
		.push          (push),
		.push_chan     (push_chan),
		.push_sample   (push_sample)
	);

	adc_sample_fifo i_fifo (
		.clock         (clock),
		.rst_n         (rst_n),
		.push          (push),
		.push_chan     (push_chan),
		.push_sample   (push_sample),
		.pop           (pop),
		.valid         (valid),
		.pop_chan      (pop_chan),
		.pop_sample    (pop_sample),
		.credit_return (credit_return)
	);

	adc_power_monitor i_monitor (
		.clock      (clock),
		.rst_n      (rst_n),
		.hold       (hold),
		.valid      (valid),
		.pop        (pop),
		.pop_chan   (pop_chan),
		.pop_sample (pop_sample),
		.fwd_limit  (fwd_limit),
		.read_chan  (read_chan),
		.read_value (read_value),
		.fwd_alarm  (fwd_alarm)
	);

endmodule

/* testbench/adc_protocol_checker.sv */
// serial timing and credit bound assertions for the adc sequencer, bound into every sequencer
`timescale 1ns/100ps
`include "adc_macros.svh"

module adc_protocol_checker import adc_pkg::*; (
	input  logic        clock,
	input  logic        rst_n,
	input  logic        ncs,
	input  logic        sclk,
	input  logic        mosi,
	input  adc_credit_t credit_cnt
);

	int assert_fails = 0;   // read by the testbench at the end of the run

	// sclk edges belong inside a frame
	sclk_in_frame: assert property (@(posedge clock) disable iff (!rst_n)
		$changed(sclk) |-> !ncs)
		else begin
			$error("sclk changed while ncs was high");
			assert_fails++;
		end

	// converter latches mosi on the rising sclk, so it must hold across the high phase
	mosi_stable: assert property (@(posedge clock) disable iff (!rst_n)
		sclk |-> $stable(mosi))
		else begin
			$error("mosi changed while sclk was high");
			assert_fails++;
		end

	credit_bound: assert property (@(posedge clock) disable iff (!rst_n)
		credit_cnt <= adc_credit_t'(`ADC_FIFO_DEPTH))
		else begin
			$error("sequencer credit count above fifo depth");
			assert_fails++;
		end

endmodule

bind adc_spi_sequencer adc_protocol_checker i_protocol_checker (
	.clock      (clock),
	.rst_n      (rst_n),
	.ncs        (ncs),
	.sclk       (sclk),
	.mosi       (mosi),
	.credit_cnt (credit_cnt)
);

/* testbench/adc_scoreboard.sv */
// adc subsystem scoreboard: mirrors the converter from the serial pins and checks monitor outputs
`timescale 1ns/100ps
`include "adc_macros.svh"

module adc_scoreboard import adc_pkg::*; (
	input  logic        clock,
	input  logic        rst_n,
	input  logic        ncs,
	input  logic        sclk,
	input  logic        mosi,
	input  logic        miso,
	input  logic        hold,
	input  adc_sample_t fwd_limit,
	input  adc_chan_t   read_chan,
	input  adc_sample_t read_value,
	input  logic        fwd_alarm,
	output int          error_count,
	output int          frames_seen,
	output int          pending       // results between converter and monitor store
);

	adc_sample_t store [`ADC_NUM_CHANNELS];   // expected monitor contents
	logic [14:0] fifo_q [$];                  // {chan, sample} in push order
	logic [14:0] entry;
	logic [15:0] mosi_word;
	logic [15:0] miso_word;
	adc_chan_t   exp_addr;                    // scan order the sequencer must follow
	adc_chan_t   last_addr;                   // owner of the result in the current frame
	adc_chan_t   addr;
	adc_chan_t   exp_chan;
	adc_sample_t exp_read;
	adc_sample_t exp_fwd;
	adc_sample_t exp_limit;
	logic        exp_alarm;
	logic        armed;
	logic        prev_ncs;
	logic        prev_sclk;
	logic [2:0]  hold_hist;                   // hold at the last three samples

	// sampled mid cycle, registered outputs and driven inputs are both settled here
	always @(negedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < `ADC_NUM_CHANNELS; i++)
				store[i] = '0;
			fifo_q.delete();
			exp_addr    = '0;
			last_addr   = '0;
			armed       = 1'b0;
			prev_ncs    = 1'b1;
			prev_sclk   = 1'b0;
			hold_hist   = '0;
			error_count = 0;
			frames_seen = 0;
		end else begin
			if (armed && read_value !== exp_read) begin
				$display("[ERROR] %0d ns: read_value of channel %0d is %h, expected %h",
					$time, exp_chan, read_value, exp_read);
				error_count++;
			end
			if (armed && fwd_alarm !== exp_alarm) begin
				$display("[ERROR] %0d ns: fwd_alarm is %b, expected %b with AIN5 %h and limit %h",
					$time, fwd_alarm, exp_alarm, exp_fwd, exp_limit);
				error_count++;
			end
			if (!ncs && sclk && !prev_sclk) begin   // rising sclk, both sides take a bit
				mosi_word = {mosi_word[14:0], mosi};
				miso_word = {miso_word[14:0], miso};
			end
			if (ncs && !prev_ncs) begin   // frame closed, result now sits in the fifo
				addr = adc_chan_t'(mosi_word[13:11]);
				if (addr !== exp_addr) begin
					$display("%0d ns: frame %0d sent address %0d on mosi, but address %0d was due",
						$time, frames_seen, addr, exp_addr);
					error_count++;
				end
				if (frames_seen > 0)   // first frame returns nothing useful
					fifo_q.push_back({last_addr, miso_word[11:0]});
				last_addr = addr;
				exp_addr  = (exp_addr == `ADC_NUM_CHANNELS - 1) ? '0 : exp_addr + 1'b1;
				frames_seen++;
			end
			// held long enough that no credit can still be on its way back
			if (&hold_hist && fifo_q.size() == `ADC_FIFO_DEPTH && !ncs) begin
				$display("%0d ns: a frame ran under hold although the fifo was full", $time);
				error_count++;
			end
			hold_hist = {hold_hist[1:0], hold};
			exp_chan  = read_chan;
			exp_read  = (read_chan < `ADC_NUM_CHANNELS) ? store[read_chan] : '0;
			exp_fwd   = store[`ADC_FWD_CHANNEL];
			exp_limit = fwd_limit;
			exp_alarm = (exp_fwd > fwd_limit);
			armed     = 1'b1;
			if (!hold && fifo_q.size() > 0) begin   // monitor takes the head at the next edge
				entry = fifo_q.pop_front();
				if (entry[14:12] < `ADC_NUM_CHANNELS)
					store[entry[14:12]] = entry[11:0];
			end
			pending   = fifo_q.size();
			prev_ncs  = ncs;
			prev_sclk = sclk;
		end
	end

endmodule

/* testbench/tb_adc_subsystem.sv */
// adc subsystem testbench: converter model fed from the stimulus file, hold and limit stimulus
`timescale 1ns/100ps
`include "adc_macros.svh"

module tb_adc_subsystem import adc_pkg::*; ();

	localparam int num_frames   = 30;
	localparam int frame_cycles = 1 + `ADC_FRAME_BITS * `ADC_SCLK_DIV;
	localparam int min_hold     = frame_cycles * (`ADC_FIFO_DEPTH + 1);   // enough to fill the fifo
	localparam int max_hold     = min_hold + 255;

	logic        clock     = 1'b0;
	logic        rst_n     = 1'b0;
	logic        miso      = 1'b0;
	logic        hold      = 1'b0;
	adc_sample_t fwd_limit = '0;
	adc_chan_t   read_chan = '0;
	logic        ncs;
	logic        sclk;
	logic        mosi;
	logic        fwd_alarm;
	adc_sample_t read_value;
	adc_sample_t stim [3*num_frames];   // sample, hold flag, limit per frame
	logic [31:0] rnd = 32'hbbd4_d888;
	logic [15:0] frame_word;            // what the converter shifts out this frame
	int          bit_idx     = 0;
	int          frame_idx   = 0;
	int          hold_left   = 0;
	int          holds       = 0;
	int          cycles      = 0;
	int          cycle_limit = 0;
	logic        ncs_seen    = 1'b1;
	logic        sclk_seen   = 1'b0;
	int          sb_errors;
	int          frames_seen;
	int          pending;

	always #50 clock = ~clock;

	always @(posedge clock)
		cycles <= cycles + 1;

	adc_subsystem i_dut (
		.clock      (clock),
		.rst_n      (rst_n),
		.ncs        (ncs),
		.sclk       (sclk),
		.mosi       (mosi),
		.miso       (miso),
		.hold       (hold),
		.fwd_limit  (fwd_limit),
		.read_chan  (read_chan),
		.read_value (read_value),
		.fwd_alarm  (fwd_alarm)
	);

	adc_scoreboard i_scoreboard (
		.clock       (clock),
		.rst_n       (rst_n),
		.ncs         (ncs),
		.sclk        (sclk),
		.mosi        (mosi),
		.miso        (miso),
		.hold        (hold),
		.fwd_limit   (fwd_limit),
		.read_chan   (read_chan),
		.read_value  (read_value),
		.fwd_alarm   (fwd_alarm),
		.error_count (sb_errors),
		.frames_seen (frames_seen),
		.pending     (pending)
	);

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic close_run(input bit timed_out);
		int fails;
		fails = sb_errors + i_dut.i_sequencer.i_protocol_checker.assert_fails;
		$display("closing: %0d errors (%0d scoreboard, %0d assertion) after %0d frames",
			fails, sb_errors, i_dut.i_sequencer.i_protocol_checker.assert_fails, frames_seen);
		if (timed_out || fails != 0)
			$display("SIMULATION FAILED");
		else
			$display("SIMULATION PASSED");
		$finish;
	endtask

	// converter model, all pins driven 10 ns after the rising edge
	always @(posedge clock) begin
		#10;
		if (rst_n) begin
			if (!ncs && ncs_seen) begin   // ncs fell, first leading zero goes out at once
				frame_word = (frame_idx < num_frames) ? {4'b0000, stim[3*frame_idx]} : '0;
				bit_idx    = 15;
				miso       = frame_word[15];
				if (frame_idx < num_frames) begin
					fwd_limit = stim[3*frame_idx+2];
					if (stim[3*frame_idx+1] != '0 && hold_left == 0) begin
						rnd       = next_random(rnd);
						hold_left = min_hold + int'(rnd % 256);
					end
				end
				frame_idx++;
			end else if (!ncs && !sclk && sclk_seen && bit_idx > 0) begin   // shift on falling sclk
				bit_idx--;
				miso = frame_word[bit_idx];
			end
			hold = (hold_left != 0);
			if (hold_left != 0)
				hold_left--;
			rnd       = next_random(rnd);
			read_chan = adc_chan_t'(rnd % `ADC_NUM_CHANNELS);
		end
		ncs_seen  = ncs;
		sclk_seen = sclk;
	end

	initial begin
		$readmemh("testbench/adc_stimulus.txt", stim);
		for (int i = 0; i < num_frames; i++)
			if (stim[3*i+1] != '0)
				holds++;
		cycle_limit = (num_frames * frame_cycles + holds * max_hold) * 2;
		repeat (5) @(posedge clock);
		#10 rst_n = 1'b1;
		while (frames_seen < num_frames || pending != 0 || hold)
			@(posedge clock);
		repeat (3) @(posedge clock);   // store update, read register, last compare
		close_run(1'b0);
	end

	initial begin
		@(posedge rst_n);
		while (cycles < cycle_limit)
			@(posedge clock);
		$display("timeout: run still busy after %0d cycles, limit was %0d", cycles, cycle_limit);
		close_run(1'b1);
	end

endmodule

/* testbench/adc_stimulus.txt */
// columns: sample returned in this frame, hold flag (1 raises hold at frame start), fwd_limit
// one line per frame, all hex; the frame 0 result is dropped by the sequencer
fff 0 800
111 0 800
222 0 800
333 0 800
444 0 800
900 0 800
0a1 0 800
1b2 0 800
2c3 1 800
3d4 0 800
700 0 800
5e5 0 800
6f6 0 600
707 0 600
818 0 600
600 0 600
a2a 0 600
b3b 0 600
c4c 0 5ff
d5d 0 5ff
fff 0 5ff
0f0 1 5ff
1e1 0 fff
2d2 0 fff
3c3 0 fff
123 0 fff
5a5 0 fff
6b6 0 000
7c7 0 000
8d8 0 000

/* all.f */
+incdir+include
design/adc_pkg.sv
design/adc_spi_sequencer.sv
design/adc_sample_fifo.sv
design/adc_power_monitor.sv
design/adc_subsystem.sv
testbench/adc_protocol_checker.sv
testbench/adc_scoreboard.sv
testbench/tb_adc_subsystem.sv

/* Bender.yml */
package:
  name: adc_subsystem

sources:
  - include_dirs:
      - include
    files:
      - design/adc_pkg.sv
      - design/adc_spi_sequencer.sv
      - design/adc_sample_fifo.sv
      - design/adc_power_monitor.sv
      - design/adc_subsystem.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/adc_protocol_checker.sv
      - testbench/adc_scoreboard.sv
      - testbench/tb_adc_subsystem.sv
